// File: sources.f
common/display_pkg.sv
common/pet_pkg.sv
sprite/sprite_ram.sv
sprite/frame_select.sv
status_bar/status_bar_overlay.sv
logic/pet_display.sv
tests/pet_display_checker.sv
tests/tb_clock_gen.sv
tests/tb_pet_display.sv

// File: tests/tb_pet_display.sv
module tb_pet_display;
    import display_pkg::*;
    import pet_pkg::*;

    localparam int ANIM_TICK = 64;
    localparam int DRIVE_DLY = 2;

    logic         clk;
    logic         rst_n;
    pet_state_t   pet_state;
    need_t        happy;
    need_t        hunger;
    need_t        sleep;
    byte_idx_t    byte_idx;
    logic         load_we;
    sprite_addr_t load_addr;
    pixel_byte_t  load_data;
    pixel_byte_t  pixel_byte;

    pixel_byte_t  model [SPRITE_DEPTH];  // Copy of everything loaded
    logic [31:0]  lfsr = 32'h22b368ce;
    int           errors = 0;
    int           timeouts = 0;
    int           waited;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(10)) clock_gen0 (.clk(clk), .o_rst_n(rst_n));

    pet_display #(.ANIM_TICK_CYCLES(ANIM_TICK)) dut0 (
        .clk(clk), .i_rst_n(rst_n), .i_pet_state(pet_state),
        .i_happy(happy), .i_hunger(hunger), .i_sleep(sleep), .i_byte_idx(byte_idx),
        .i_load_we(load_we), .i_load_addr(load_addr), .i_load_data(load_data),
        .o_pixel_byte(pixel_byte)
    );

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    function automatic pixel_byte_t rand_byte();
        pixel_byte_t b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);  // One step per bit
        end
        return b;
    endfunction

    // Segment k is full above 110-20k and half above 100-20k
    function automatic pixel_byte_t seg_expect(need_t need, int k);
        if (int'(need) > 110 - 20 * k) return BAR_FULL;
        if (int'(need) > 100 - 20 * k) return BAR_HALF;
        return 8'h00;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic check_byte(input pixel_byte_t got, input pixel_byte_t exp, input string msg);
        if (got !== exp) note_error($sformatf("%s got %02h expected %02h", msg, got, exp));
    endtask

    task automatic check_frame(input frame_num_t got, input frame_num_t exp, input string msg);
        if (got !== exp) note_error($sformatf("%s frame %0d expected %0d", msg, got, exp));
    endtask

    task automatic read_byte(input byte_idx_t idx, output pixel_byte_t data);
        byte_idx = idx;
        @(posedge clk);
        #DRIVE_DLY;
        data = pixel_byte;
    endtask

    task automatic load_sprites();
        pixel_byte_t b;
        for (int a = 0; a < SPRITE_DEPTH; a++) begin
            b = rand_byte();
            if (a % FRAME_BYTES == 0) begin
                b = pixel_byte_t'(a / FRAME_BYTES);  // Byte 0 tags the frame
            end else if (a >= BASE_DEAD * FRAME_BYTES && (b == BAR_FULL || b == BAR_HALF)) begin
                b = b ^ 8'h01;
            end
            model[a] = b;
            load_we = 1'b1;
            load_addr = sprite_addr_t'(a);
            load_data = b;
            @(posedge clk);
            #DRIVE_DLY;
        end
        load_we = 1'b0;
    endtask

    // Byte 0 is read before and after the access to pin down the frame
    task automatic check_sprite_at(input byte_idx_t idx, input int base, input int count);
        pixel_byte_t f0;
        pixel_byte_t f1;
        pixel_byte_t d;
        int tries;
        tries = 0;
        do begin
            read_byte(0, f0);
            read_byte(idx, d);
            read_byte(0, f1);
            tries++;
        end while (f0 != f1 && tries < 4);
        if (f0 != f1) begin
            timeouts++;
            $display("Frame did not hold still while reading byte %0d", idx);
        end else if (int'(f0) < base || int'(f0) >= base + count) begin
            note_error($sformatf("byte %0d read from frame %0d outside %0d..%0d",
                                 idx, f0, base, base + count - 1));
        end else begin
            check_byte(d, model[{frame_num_t'(f0), idx}], $sformatf("sprite byte %0d", idx));
        end
    endtask

    task automatic check_bar(input int base, input need_t need);
        pixel_byte_t got;
        byte_idx_t idx;
        for (int g = 0; g < 5; g++) begin
            for (int k = 1; k <= 5; k++) begin
                idx = byte_idx_t'((base + g) * 8 + k);
                read_byte(idx, got);
                check_byte(got, seg_expect(need, k), $sformatf("bar byte %0d need %0d", idx, need));
            end
        end
    endtask

    task automatic test_intro();
        pixel_byte_t got;
        pet_state = INTRO;
        byte_idx = 0;
        for (int i = 1; i <= FRAME_BYTES; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            got = pixel_byte;  // Result of index i-1
            byte_idx = byte_idx_t'(i);
            check_byte(got, model[i - 1], $sformatf("intro byte %0d", i - 1));
        end
    endtask

    task automatic mood_case(input need_t h, input need_t hu, input need_t s, input mood_t m);
        pixel_byte_t got;
        pet_state = IDLE;
        happy = h;
        hunger = hu;
        sleep = s;
        @(posedge clk);  // Mood register settles
        #DRIVE_DLY;
        read_byte(0, got);
        check_frame(frame_num_t'(got), frame_num_t'(BASE_IDLE + int'(m)),
                    $sformatf("idle needs %0d/%0d/%0d", h, hu, s));
    endtask

    task automatic test_idle_mood();
        mood_case(8'd95, 8'd95, 8'd95, MOOD_CONTENT);
        mood_case(8'd5, 8'd95, 8'd95, MOOD_SAD);
        mood_case(8'd5, 8'd5, 8'd5, MOOD_SAD);
        mood_case(8'd50, 8'd5, 8'd5, MOOD_HUNGRY);
        mood_case(8'd50, 8'd50, 8'd5, MOOD_TIRED);
        mood_case(8'd50, 8'd15, 8'd50, MOOD_WEAK);
        mood_case(8'd10, 8'd50, 8'd50, MOOD_WEAK);
        mood_case(8'd91, 8'd91, 8'd90, MOOD_NEUTRAL);
        mood_case(8'd50, 8'd50, 8'd50, MOOD_NEUTRAL);
    endtask

    task automatic test_bars();
        need_t levels [6];
        int fbase;
        int fcount;
        levels = '{8'd0, 8'd5, 8'd15, 8'd45, 8'd85, 8'd95};
        for (int s = 0; s < 2; s++) begin
            pet_state = (s == 0) ? IDLE : EATING;
            fbase = (s == 0) ? BASE_IDLE : BASE_EAT;
            fcount = (s == 0) ? N_IDLE : N_EAT;
            for (int lv = 0; lv < 6; lv++) begin
                happy = levels[lv];
                hunger = levels[(lv + 2) % 6];
                sleep = levels[(lv + 4) % 6];
                check_bar(BAR_GROUP_HAPPY, happy);
                check_bar(BAR_GROUP_HUNGER, hunger);
                check_bar(BAR_GROUP_SLEEP, sleep);
                for (int g = BAR_GROUP_HAPPY; g < BAR_GROUP_HAPPY + 5; g++) begin
                    check_sprite_at(byte_idx_t'(g * 8), fbase, fcount);
                    check_sprite_at(byte_idx_t'(g * 8 + 6), fbase, fcount);
                    check_sprite_at(byte_idx_t'(g * 8 + 7), fbase, fcount);
                end
            end
        end
    endtask

    task automatic test_dead();
        int bases [3];
        bases = '{BAR_GROUP_HAPPY, BAR_GROUP_HUNGER, BAR_GROUP_SLEEP};
        pet_state = DEAD;
        happy = 8'd95;  // Full bars would be visible if not hidden
        hunger = 8'd95;
        sleep = 8'd95;
        foreach (bases[b]) begin
            for (int g = 0; g < 5; g++) begin
                for (int k = 1; k <= 5; k++) begin
                    check_sprite_at(byte_idx_t'((bases[b] + g) * 8 + k), BASE_DEAD, N_DEAD);
                end
            end
        end
    endtask

    task automatic watch_anim(input pet_state_t st, input int base, input int count);
        pixel_byte_t got;
        frame_num_t prev;
        int changes;
        int idle;
        pet_state = st;
        read_byte(0, got);
        prev = frame_num_t'(got);
        if (int'(prev) < base || int'(prev) >= base + count) begin
            note_error($sformatf("%s starts outside its frames at %0d", st.name(), prev));
        end
        changes = 0;
        idle = 0;
        while (changes <= count && idle < 4 * ANIM_TICK) begin
            read_byte(0, got);
            idle++;
            if (frame_num_t'(got) != prev) begin
                check_frame(frame_num_t'(got),
                            frame_num_t'(base + (int'(prev) - base + 1) % count),
                            $sformatf("%s step", st.name()));
                prev = frame_num_t'(got);
                changes++;
                idle = 0;
            end
        end
        if (changes <= count) begin
            timeouts++;
            $display("Animation in %s stopped before wrapping around", st.name());
        end
    endtask

    initial begin
        pet_state = IDLE;  // Bar byte keeps the output defined during loading
        happy = 8'd50;
        hunger = 8'd50;
        sleep = 8'd50;
        byte_idx = byte_idx_t'(BAR_GROUP_HAPPY * 8 + 1);
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        @(posedge clk);
        waited = 0;
        while (!rst_n && waited < 50) begin
            @(posedge clk);
            waited++;
        end
        if (!rst_n) begin
            timeouts++;
            $display("Reset was never released");
        end
        #DRIVE_DLY;
        load_sprites();
        test_intro();
        test_idle_mood();
        test_bars();
        test_dead();
        watch_anim(SLEEPING, BASE_SLEEP, N_SLEEP);
        watch_anim(EATING, BASE_EAT, N_EAT);
        watch_anim(TEACHING, BASE_TEACH, N_TEACH);
        watch_anim(DEAD, BASE_DEAD, N_DEAD);
        $display("Errors: %0d compare, %0d assertion, %0d timeout",
                 errors, dut0.checker0.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && dut0.checker0.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic o_rst_n
);

    initial begin
        clk     = 1'b0;
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 o_rst_n = 1'b1;  // Released just after an edge, like the other inputs
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tests/pet_display_checker.sv
module pet_display_checker (
    input logic                      clk,
    input logic                      i_rst_n,
    input pet_pkg::pet_state_t       i_pet_state,
    input display_pkg::byte_idx_t    i_byte_idx,
    input logic                      i_load_we,
    input display_pkg::sprite_addr_t i_load_addr,
    input display_pkg::pixel_byte_t  o_pixel_byte
);
    import display_pkg::*;
    import pet_pkg::*;

    int fail_count = 0;  // Number of assertion failures

    // Segment byte of any of the three bars
    function automatic logic at_bar_seg(byte_idx_t idx);
        int grp;
        grp = int'(idx[9:3]);
        return idx[2:0] >= 3'd1 && idx[2:0] <= 3'd5 &&
               ((grp >= BAR_GROUP_HAPPY && grp < BAR_GROUP_HAPPY + BAR_GROUPS) ||
                (grp >= BAR_GROUP_HUNGER && grp < BAR_GROUP_HUNGER + BAR_GROUPS) ||
                (grp >= BAR_GROUP_SLEEP && grp < BAR_GROUP_SLEEP + BAR_GROUPS));
    endfunction

    a_out_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_pixel_byte))
        else begin
            $error("o_pixel_byte is unknown");
            fail_count++;
        end

    // Dead frames hold no bar patterns, so none may show up there
    a_dead_no_bar: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_pet_state == DEAD && at_bar_seg(i_byte_idx)) |=>
        (o_pixel_byte != BAR_FULL && o_pixel_byte != BAR_HALF))
        else begin
            $error("Bar pattern shown in DEAD state");
            fail_count++;
        end

    a_load_range: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_load_we |-> int'(i_load_addr) < SPRITE_DEPTH)
        else begin
            $error("Load address beyond sprite memory");
            fail_count++;
        end

endmodule

bind pet_display pet_display_checker checker0 (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_pet_state (i_pet_state),
    .i_byte_idx  (i_byte_idx),
    .i_load_we   (i_load_we),
    .i_load_addr (i_load_addr),
    .o_pixel_byte(o_pixel_byte)
);

// File: logic/pet_display.sv
module pet_display #(
    parameter int ANIM_TICK_CYCLES = 2 ** 23
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  pet_pkg::pet_state_t       i_pet_state,
    input  pet_pkg::need_t            i_happy,
    input  pet_pkg::need_t            i_hunger,
    input  pet_pkg::need_t            i_sleep,
    input  display_pkg::byte_idx_t    i_byte_idx,
    input  logic                      i_load_we,
    input  display_pkg::sprite_addr_t i_load_addr,
    input  display_pkg::pixel_byte_t  i_load_data,
    output display_pkg::pixel_byte_t  o_pixel_byte
);
    import display_pkg::*;

    frame_num_t   frame;
    sprite_addr_t rd_addr;
    pixel_byte_t  sprite_byte;

    assign rd_addr = {frame, i_byte_idx};  // Frame selects the 1 KiB page

    frame_select #(
        .ANIM_TICK_CYCLES(ANIM_TICK_CYCLES)
    ) frame_select0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_pet_state(i_pet_state),
        .i_happy    (i_happy),
        .i_hunger   (i_hunger),
        .i_sleep    (i_sleep),
        .o_frame    (frame)
    );

    sprite_ram sprite_ram0 (
        .clk    (clk),
        .i_we   (i_load_we),
        .i_waddr(i_load_addr),
        .i_wdata(i_load_data),
        .i_raddr(rd_addr),
        .o_rdata(sprite_byte)
    );

    // Bar decision is registered alongside the RAM read
    status_bar_overlay status_bar_overlay0 (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_pet_state  (i_pet_state),
        .i_happy      (i_happy),
        .i_hunger     (i_hunger),
        .i_sleep      (i_sleep),
        .i_byte_idx   (i_byte_idx),
        .i_sprite_byte(sprite_byte),
        .o_pixel_byte (o_pixel_byte)
    );

endmodule

// File: status_bar/status_bar_overlay.sv
module status_bar_overlay (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  pet_pkg::pet_state_t      i_pet_state,
    input  pet_pkg::need_t           i_happy,
    input  pet_pkg::need_t           i_hunger,
    input  pet_pkg::need_t           i_sleep,
    input  display_pkg::byte_idx_t   i_byte_idx,
    input  display_pkg::pixel_byte_t i_sprite_byte,
    output display_pkg::pixel_byte_t o_pixel_byte
);
    import display_pkg::*;
    import pet_pkg::*;

    logic [6:0]  group;      // 8-byte column group
    logic [2:0]  offset;     // Byte inside the group
    logic        in_bar;
    logic        seg_ok;
    logic        bars_on;
    logic        hit;
    need_t       bar_need;
    pixel_byte_t bar_byte;
    logic        sprite_sel;
    pixel_byte_t bar_byte_q;

    function automatic logic group_in_bar(logic [6:0] grp, int base);
        return int'(grp) >= base && int'(grp) < base + BAR_GROUPS;
    endfunction

    // Segment pattern for segment seg of a bar showing need
    function automatic pixel_byte_t seg_byte(need_t need, int seg);
        if (int'(need) > BAR_FULL_TOP - BAR_STEP * seg) begin
            return BAR_FULL;
        end else if (int'(need) > BAR_HALF_TOP - BAR_STEP * seg) begin
            return BAR_HALF;
        end
        return '0;
    endfunction

    assign group  = i_byte_idx[9:3];
    assign offset = i_byte_idx[2:0];

    always_comb begin
        in_bar   = 1'b1;
        bar_need = i_happy;
        if (group_in_bar(group, BAR_GROUP_HUNGER)) begin
            bar_need = i_hunger;
        end else if (group_in_bar(group, BAR_GROUP_SLEEP)) begin
            bar_need = i_sleep;
        end else if (!group_in_bar(group, BAR_GROUP_HAPPY)) begin
            in_bar = 1'b0;
        end
    end

    assign seg_ok   = int'(offset) >= BAR_FIRST_SEG && int'(offset) < BAR_FIRST_SEG + BAR_SEGS;
    assign bars_on  = (i_pet_state != INTRO) && (i_pet_state != DEAD);  // Clean intro and grave
    assign hit      = in_bar && seg_ok && bars_on;
    assign bar_byte = seg_byte(bar_need, int'(offset));

    // Reset leaves the bar path selected with a zero byte, so output starts at 0
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sprite_sel <= 1'b0;
            bar_byte_q <= '0;
        end else begin
            sprite_sel <= !hit;
            bar_byte_q <= bar_byte;
        end
    end

    assign o_pixel_byte = sprite_sel ? i_sprite_byte : bar_byte_q;

endmodule

// File: sprite/frame_select.sv
module frame_select #(
    parameter int ANIM_TICK_CYCLES = 2 ** 23
) (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  pet_pkg::pet_state_t     i_pet_state,
    input  pet_pkg::need_t          i_happy,
    input  pet_pkg::need_t          i_hunger,
    input  pet_pkg::need_t          i_sleep,
    output display_pkg::frame_num_t o_frame
);
    import display_pkg::*;
    import pet_pkg::*;

    localparam int TICK_W = $clog2(ANIM_TICK_CYCLES);

    logic [TICK_W-1:0] tick_cnt;
    logic              tick;
    anim_idx_t         idx_sleep;
    anim_idx_t         idx_eat;
    anim_idx_t         idx_teach;
    anim_idx_t         idx_dead;
    mood_t             mood;

    // Advance one frame, back to 0 after the last one
    function automatic anim_idx_t next_idx(anim_idx_t idx, int count);
        if (int'(idx) == count - 1) begin
            return '0;
        end
        return anim_idx_t'(idx + 1'b1);
    endfunction

    assign tick = (tick_cnt == TICK_W'(ANIM_TICK_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // All animations keep running whatever the current state
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            idx_sleep <= '0;
            idx_eat   <= '0;
            idx_teach <= '0;
            idx_dead  <= '0;
        end else if (tick) begin
            idx_sleep <= next_idx(idx_sleep, N_SLEEP);
            idx_eat   <= next_idx(idx_eat, N_EAT);
            idx_teach <= next_idx(idx_teach, N_TEACH);
            idx_dead  <= next_idx(idx_dead, N_DEAD);
        end
    end

    // First matching rule wins
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            mood <= MOOD_NEUTRAL;
        end else if (i_happy > MOOD_HIGH && i_hunger > MOOD_HIGH && i_sleep > MOOD_HIGH) begin
            mood <= MOOD_CONTENT;
        end else if (i_happy < MOOD_CRIT) begin
            mood <= MOOD_SAD;
        end else if (i_hunger < MOOD_CRIT) begin
            mood <= MOOD_HUNGRY;
        end else if (i_sleep < MOOD_CRIT) begin
            mood <= MOOD_TIRED;
        end else if (i_happy < MOOD_LOW || i_hunger < MOOD_LOW || i_sleep < MOOD_LOW) begin
            mood <= MOOD_WEAK;
        end else begin
            mood <= MOOD_NEUTRAL;
        end
    end

    always_comb begin
        case (i_pet_state)
            INTRO:    o_frame = frame_num_t'(BASE_INTRO);
            IDLE:     o_frame = frame_num_t'(BASE_IDLE) + frame_num_t'(mood);
            SLEEPING: o_frame = frame_num_t'(BASE_SLEEP) + frame_num_t'(idx_sleep);
            EATING:   o_frame = frame_num_t'(BASE_EAT) + frame_num_t'(idx_eat);
            TEACHING: o_frame = frame_num_t'(BASE_TEACH) + frame_num_t'(idx_teach);
            DEAD:     o_frame = frame_num_t'(BASE_DEAD) + frame_num_t'(idx_dead);
            default:  o_frame = '0;  // Unknown code falls back to frame 0
        endcase
    end

endmodule

// File: sprite/sprite_ram.sv
module sprite_ram (
    input  logic                      clk,
    input  logic                      i_we,
    input  display_pkg::sprite_addr_t i_waddr,
    input  display_pkg::pixel_byte_t  i_wdata,
    input  display_pkg::sprite_addr_t i_raddr,
    output display_pkg::pixel_byte_t  o_rdata
);
    import display_pkg::*;

    // All 31 frames back to back at 1 KiB each
    pixel_byte_t mem [SPRITE_DEPTH];

    // Load port
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Display read with one cycle latency
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

// File: common/pet_pkg.sv
package pet_pkg;

    // One-hot style codes as used by the game logic
    typedef enum logic [4:0] {
        INTRO    = 5'd0,
        IDLE     = 5'd1,
        SLEEPING = 5'd2,
        EATING   = 5'd4,
        TEACHING = 5'd8,
        DEAD     = 5'd16
    } pet_state_t;

    typedef logic [7:0] need_t;      // Happiness, hunger or sleep level
    typedef logic [2:0] anim_idx_t;  // Frame index within one state

    // Frames per state
    localparam int N_IDLE  = 6;
    localparam int N_SLEEP = 4;
    localparam int N_EAT   = 5;
    localparam int N_TEACH = 7;
    localparam int N_DEAD  = 8;

    // First global frame of each state in sprite memory
    localparam int BASE_INTRO = 0;
    localparam int BASE_IDLE  = 1;
    localparam int BASE_SLEEP = 7;
    localparam int BASE_EAT   = 11;
    localparam int BASE_TEACH = 16;
    localparam int BASE_DEAD  = 23;

    // Mood thresholds on the needs
    localparam int MOOD_HIGH = 90;
    localparam int MOOD_LOW  = 20;
    localparam int MOOD_CRIT = 10;

    // Idle picture given as an offset from BASE_IDLE
    typedef enum logic [2:0] {
        MOOD_CONTENT = 3'd0,
        MOOD_HUNGRY  = 3'd1,
        MOOD_SAD     = 3'd2,
        MOOD_NEUTRAL = 3'd3,
        MOOD_WEAK    = 3'd4,
        MOOD_TIRED   = 3'd5
    } mood_t;

endpackage

// File: common/display_pkg.sv
package display_pkg;

    // 128x64 mono panel with 8 vertical pixels per byte
    localparam int FRAME_BYTES = 1024;
    localparam int NUM_FRAMES  = 31;
    localparam int SPRITE_DEPTH = NUM_FRAMES * FRAME_BYTES;

    typedef logic [9:0]  byte_idx_t;     // Byte position inside one frame
    typedef logic [7:0]  pixel_byte_t;
    typedef logic [4:0]  frame_num_t;    // Global sprite frame number
    typedef logic [14:0] sprite_addr_t;  // {frame_num_t, byte_idx_t}

    // Status bars
    // Each bar covers five consecutive 8-byte groups
    localparam int BAR_GROUP_HAPPY  = 8;
    localparam int BAR_GROUP_HUNGER = 18;
    localparam int BAR_GROUP_SLEEP  = 28;
    localparam int BAR_GROUPS       = 5;

    // Segment bytes sit at offsets 1..5 inside a group
    localparam int BAR_FIRST_SEG = 1;
    localparam int BAR_SEGS      = 5;

    // Segment k is full above 110-20k, half above 100-20k
    localparam int BAR_FULL_TOP = 110;
    localparam int BAR_HALF_TOP = 100;
    localparam int BAR_STEP     = 20;

    localparam pixel_byte_t BAR_FULL = 8'hEE;
    localparam pixel_byte_t BAR_HALF = 8'hE0;

endpackage
